// File: e300_radio_io_settings.svh
`ifndef E300_RADIO_IO_SETTINGS_SVH
`define E300_RADIO_IO_SETTINGS_SVH

// ------------------------------------------------------------------------
// Sample format
// ------------------------------------------------------------------------

// Width of one I or Q component on the AD9361 data bus
// One component per DDR edge, so two per siso_clk2 cycle
`define E300_SAMPLE_W 12

// ------------------------------------------------------------------------
// Mode control
// ------------------------------------------------------------------------

// Flops in the MIMO level synchroniser
// Mode level comes from the bus clock side, keep this at 2 or more
`define E300_SYNC_STAGES 2

`endif

// File: e300_radio_io_pkg.sv
`include "e300_radio_io_settings.svh"

package e300_radio_io_pkg;

   // ---------------------------------------------------------------------
   // Baseband sample types
   // ---------------------------------------------------------------------

   // One complex sample, I in the upper half
   typedef struct packed {
      logic [`E300_SAMPLE_W-1:0] i;
      logic [`E300_SAMPLE_W-1:0] q;
   } sample_t;

   // Both radio channels side by side
   // Channel 0 sits in the upper half
   typedef struct packed {
      sample_t ch0;
      sample_t ch1;
   } chan_pair_t;

   // ---------------------------------------------------------------------
   // DDR pin words, both edges of one siso_clk2 cycle
   // ---------------------------------------------------------------------

   // RX side
   // Rising edge carries Q, falling edge carries I
   typedef struct packed {
      logic                      frame;
      logic [`E300_SAMPLE_W-1:0] rise;
      logic [`E300_SAMPLE_W-1:0] fall;
   } rx_ddr_t;

   // TX side
   // Rising edge carries I, falling edge carries Q
   typedef struct packed {
      logic                      frame_rise;
      logic                      frame_fall;
      logic [`E300_SAMPLE_W-1:0] rise;
      logic [`E300_SAMPLE_W-1:0] fall;
   } tx_ddr_t;

endpackage

// File: mode_phase_ctrl.sv
`timescale 1ns/1ps
`include "e300_radio_io_settings.svh"

module mode_phase_ctrl (
   input  logic siso_clk2,
   input  logic arst_n_i,
   input  logic mimo_i,
   output logic mimo_sync_o,
   output logic radio_strobe_o
);

   // ------------------------------------------------------------------------
   // MIMO level synchroniser
   // ------------------------------------------------------------------------

   // Shift chain, mimo_i enters at bit 0
   logic [`E300_SYNC_STAGES-1:0] sync_q;

   always_ff @(posedge siso_clk2 or negedge arst_n_i) begin
      if (!arst_n_i) begin
         // Start in SISO mode
         sync_q <= '0;
      end else begin
         sync_q <= {sync_q[`E300_SYNC_STAGES-2:0], mimo_i};
      end
   end

   assign mimo_sync_o = sync_q[`E300_SYNC_STAGES-1];

   // ------------------------------------------------------------------------
   // Radio-rate phase and strobe
   // ------------------------------------------------------------------------

   // Toggles every cycle in MIMO mode, parked at 0 in SISO mode
   logic phase_q;

   always_ff @(posedge siso_clk2 or negedge arst_n_i) begin
      if (!arst_n_i) begin
         phase_q <= 1'b0;
      end else if (!mimo_sync_o) begin
         phase_q <= 1'b0;
      end else begin
         phase_q <= ~phase_q;
      end
   end

   // SISO runs at full rate, MIMO at half rate
   // First MIMO strobe lands one cycle after mimo_sync_o rises
   assign radio_strobe_o = mimo_sync_o ? phase_q : 1'b1;

   // Half rate in MIMO, never two strobes back to back
   a_mimo_strobe_gap : assert property (@(posedge siso_clk2) disable iff (!arst_n_i)
      (mimo_sync_o && radio_strobe_o) |=> !(mimo_sync_o && radio_strobe_o));

endmodule

// File: rx_deinterleave.sv
`timescale 1ns/1ps

module rx_deinterleave
   import e300_radio_io_pkg::*;
(
   input  logic       siso_clk2,
   input  logic       arst_n_i,
   input  rx_ddr_t    rx_pins_i,
   input  logic       mimo_sync_i,
   output chan_pair_t rx_chan_o,
   output logic       rx_valid_o
);

   // ------------------------------------------------------------------------
   // Capture stage
   // ------------------------------------------------------------------------

   // Registered pin word
   // I from the falling edge, Q from the rising edge
   sample_t cap_q;
   logic    cap_frame_q;

   always_ff @(posedge siso_clk2 or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cap_q       <= '0;
         cap_frame_q <= 1'b0;
      end else begin
         cap_q.i     <= rx_pins_i.fall;
         cap_q.q     <= rx_pins_i.rise;
         // Frame half sampled with the I word
         cap_frame_q <= rx_pins_i.frame;
      end
   end

   // ------------------------------------------------------------------------
   // Channel steering
   // ------------------------------------------------------------------------

   // Channel 0 sample waiting for its channel 1 partner
   sample_t    pend_q;

   // Output pair and its valid pulse
   chan_pair_t chan_q;
   logic       valid_q;

   always_ff @(posedge siso_clk2 or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pend_q  <= '0;
         chan_q  <= '0;
         valid_q <= 1'b0;
      end else if (!mimo_sync_i) begin
         // SISO
         // Same sample on both channels, every cycle
         chan_q.ch0 <= cap_q;
         chan_q.ch1 <= cap_q;
         valid_q    <= 1'b1;
      end else if (cap_frame_q) begin
         // MIMO, frame high
         // Channel 0 half of the pair, hold it
         pend_q  <= cap_q;
         valid_q <= 1'b0;
      end else begin
         // MIMO, frame low
         // Channel 1 half completes the pair
         // Back to back frame-low words reuse the last held sample
         chan_q.ch0 <= pend_q;
         chan_q.ch1 <= cap_q;
         valid_q    <= 1'b1;
      end
   end

   // ------------------------------------------------------------------------
   // Outputs
   // ------------------------------------------------------------------------

   // Two cycles from pin word to channel pair
   assign rx_chan_o  = chan_q;
   assign rx_valid_o = valid_q;

   // In MIMO mode a valid pair always follows a frame-low capture
   a_mimo_valid_frame : assert property (@(posedge siso_clk2) disable iff (!arst_n_i)
      (rx_valid_o && $past(mimo_sync_i)) |-> !$past(cap_frame_q));

endmodule

// File: tx_interleave.sv
`timescale 1ns/1ps

module tx_interleave
   import e300_radio_io_pkg::*;
(
   input  logic       siso_clk2,
   input  logic       arst_n_i,
   input  chan_pair_t tx_chan_i,
   input  logic       mimo_sync_i,
   input  logic       radio_strobe_i,
   output tx_ddr_t    tx_pins_o
);

   // ------------------------------------------------------------------------
   // SISO loopback select
   // ------------------------------------------------------------------------

   // Either channel can drive the single SISO stream
   // A zero channel 0 component hands over to channel 1, per component
   sample_t loop_sel;

   always_comb begin
      loop_sel.i = (tx_chan_i.ch0.i != '0) ? tx_chan_i.ch0.i : tx_chan_i.ch1.i;
      loop_sel.q = (tx_chan_i.ch0.q != '0) ? tx_chan_i.ch0.q : tx_chan_i.ch1.q;
   end

   // MIMO always sends channel 0 first
   sample_t first_sel;

   assign first_sel = mimo_sync_i ? tx_chan_i.ch0 : loop_sel;

   // ------------------------------------------------------------------------
   // Channel interleave
   // ------------------------------------------------------------------------

   // Channel 1 parked here for the cycle after the strobe
   sample_t dly_q;

   always_ff @(posedge siso_clk2) begin
      if (radio_strobe_i) begin
         dly_q <= tx_chan_i.ch1;
      end
   end

   // Pin register
   // I on the rising edge, Q on the falling edge
   tx_ddr_t pins_q;

   always_ff @(posedge siso_clk2 or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pins_q <= '0;
      end else begin
         if (radio_strobe_i) begin
            pins_q.rise <= first_sel.i;
            pins_q.fall <= first_sel.q;
         end else begin
            // Second half of a MIMO pair
            pins_q.rise <= dly_q.i;
            pins_q.fall <= dly_q.q;
         end
         // Frame pair
         // MIMO gives 1/1 then 0/0, SISO gives 1/0 every cycle
         pins_q.frame_rise <= radio_strobe_i;
         pins_q.frame_fall <= radio_strobe_i & mimo_sync_i;
      end
   end

   assign tx_pins_o = pins_q;

   // Falling frame half only ever set on a MIMO channel 0 word
   a_frame_pair : assert property (@(posedge siso_clk2) disable iff (!arst_n_i)
      tx_pins_o.frame_fall |-> (tx_pins_o.frame_rise && $past(mimo_sync_i)));

endmodule

// File: e300_radio_io.sv
`timescale 1ns/1ps

module e300_radio_io
   import e300_radio_io_pkg::*;
(
   input  logic       siso_clk2,
   input  logic       arst_n_i,
   input  logic       mimo_i,
   // AD9361 pin side
   input  rx_ddr_t    rx_pins_i,
   output tx_ddr_t    tx_pins_o,
   // Baseband side
   input  chan_pair_t tx_chan_i,
   output chan_pair_t rx_chan_o,
   output logic       rx_valid_o,
   output logic       radio_strobe_o
);

   // ------------------------------------------------------------------------
   // Mode and radio-rate control
   // ------------------------------------------------------------------------

   logic mimo_sync;

   mode_phase_ctrl i_mode_phase_ctrl (
      .siso_clk2      (siso_clk2),
      .arst_n_i       (arst_n_i),
      .mimo_i         (mimo_i),
      .mimo_sync_o    (mimo_sync),
      .radio_strobe_o (radio_strobe_o)
   );

   // ------------------------------------------------------------------------
   // Sample paths
   // ------------------------------------------------------------------------

   rx_deinterleave i_rx_deinterleave (
      .siso_clk2   (siso_clk2),
      .arst_n_i    (arst_n_i),
      .rx_pins_i   (rx_pins_i),
      .mimo_sync_i (mimo_sync),
      .rx_chan_o   (rx_chan_o),
      .rx_valid_o  (rx_valid_o)
   );

   // New tx_chan_i expected on every strobe cycle
   tx_interleave i_tx_interleave (
      .siso_clk2      (siso_clk2),
      .arst_n_i       (arst_n_i),
      .tx_chan_i      (tx_chan_i),
      .mimo_sync_i    (mimo_sync),
      .radio_strobe_i (radio_strobe_o),
      .tx_pins_o      (tx_pins_o)
   );

endmodule

// File: tb_e300_radio_io.sv
`timescale 1ns/1ps
`include "e300_radio_io_settings.svh"

module tb_e300_radio_io
   import e300_radio_io_pkg::*;
();

   // ------------------------------------------------------------------------
   // Clock, reset and DUT
   // ------------------------------------------------------------------------

   logic       siso_clk2 = 1'b0;
   logic       arst_n_i;
   logic       mimo_i;
   rx_ddr_t    rx_pins_i;
   tx_ddr_t    tx_pins_o;
   chan_pair_t tx_chan_i;
   chan_pair_t rx_chan_o;
   logic       rx_valid_o;
   logic       radio_strobe_o;

   integer seed = 86;

   // 8 ns period
   always #4 siso_clk2 = ~siso_clk2;

   e300_radio_io i_dut (
      .siso_clk2      (siso_clk2),
      .arst_n_i       (arst_n_i),
      .mimo_i         (mimo_i),
      .rx_pins_i      (rx_pins_i),
      .tx_pins_o      (tx_pins_o),
      .tx_chan_i      (tx_chan_i),
      .rx_chan_o      (rx_chan_o),
      .rx_valid_o     (rx_valid_o),
      .radio_strobe_o (radio_strobe_o)
   );

   // ------------------------------------------------------------------------
   // Reference model state, one step ahead of the DUT registers
   // ------------------------------------------------------------------------

   logic [`E300_SYNC_STAGES-1:0] m_sync;
   logic                         m_phase;
   sample_t                      m_cap;
   logic                         m_cap_frame;
   sample_t                      m_pend;
   chan_pair_t                   m_chan;
   logic                         m_valid;
   sample_t                      m_dly;
   tx_ddr_t                      tx_exp_q[$];

   // Strobe seen by the DUT in the cycle after the next rising edge
   logic next_strobe;

   // Coverage counters
   int rx_siso_pairs;
   int rx_mimo_pairs;
   int tx_mimo_words;

   // ------------------------------------------------------------------------
   // Failure reporting
   // ------------------------------------------------------------------------

   task automatic report_mismatch(input string name, input logic [63:0] expected,
                                  input logic [63:0] actual);
      $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
      $display("TB FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic abort_run(input string what);
      $display("%0t %s", $time, what);
      $display("TB FAILED");
      $fatal(1, "stopped at first error");
   endtask

   // ------------------------------------------------------------------------
   // Reference functions
   // ------------------------------------------------------------------------

   // Next RX output pair from the captured sample
   // SISO copies to both channels, MIMO pairs frame 1 then frame 0
   function automatic chan_pair_t expected_rx_pair(input logic mimo, input sample_t cap,
                                                   input logic frame, input sample_t pend,
                                                   input chan_pair_t prev);
      chan_pair_t pair;
      pair = prev;
      if (!mimo) begin
         pair.ch0 = cap;
         pair.ch1 = cap;
      end else if (!frame) begin
         pair.ch0 = pend;
         pair.ch1 = cap;
      end
      return pair;
   endfunction

   // Next TX pin word
   // Strobe cycle sends channel 0 or the loopback pick, otherwise the held channel 1
   function automatic tx_ddr_t expected_tx_word(input logic mimo, input logic strobe,
                                                input chan_pair_t chan, input sample_t dly);
      tx_ddr_t word;
      sample_t src;
      if (!strobe) begin
         src = dly;
      end else if (mimo) begin
         src = chan.ch0;
      end else begin
         // Zero component on channel 0 falls back to channel 1
         src.i = (chan.ch0.i == '0) ? chan.ch1.i : chan.ch0.i;
         src.q = (chan.ch0.q == '0) ? chan.ch1.q : chan.ch0.q;
      end
      word.rise       = src.i;
      word.fall       = src.q;
      word.frame_rise = strobe;
      word.frame_fall = strobe & mimo;
      return word;
   endfunction

   // ------------------------------------------------------------------------
   // Comparison process, outputs checked on the falling edge
   // ------------------------------------------------------------------------

   task automatic compare_outputs();
      logic    strobe_exp;
      tx_ddr_t word_exp;
      strobe_exp = m_sync[`E300_SYNC_STAGES-1] ? m_phase : 1'b1;
      assert (radio_strobe_o === strobe_exp)
         else report_mismatch("radio_strobe_o", 64'(strobe_exp), 64'(radio_strobe_o));
      assert (rx_valid_o === m_valid)
         else report_mismatch("rx_valid_o", 64'(m_valid), 64'(rx_valid_o));
      if (m_valid) begin
         assert (rx_chan_o === m_chan)
            else report_mismatch("rx_chan_o", 64'(m_chan), 64'(rx_chan_o));
         if (m_sync[`E300_SYNC_STAGES-1])
            rx_mimo_pairs++;
         else
            rx_siso_pairs++;
      end
      if (tx_exp_q.size() == 0) begin
         abort_run("tx reference queue ran empty");
      end else begin
         word_exp = tx_exp_q.pop_front();
         assert (tx_pins_o === word_exp)
            else report_mismatch("tx_pins_o", 64'(word_exp), 64'(tx_pins_o));
         if (word_exp.frame_fall)
            tx_mimo_words++;
      end
   endtask

   // Step the model over the next rising edge with the inputs now on the pins
   task automatic advance_model();
      logic mimo_now;
      logic strobe_now;
      mimo_now   = m_sync[`E300_SYNC_STAGES-1];
      strobe_now = mimo_now ? m_phase : 1'b1;
      tx_exp_q.push_back(expected_tx_word(mimo_now, strobe_now, tx_chan_i, m_dly));
      if (strobe_now)
         m_dly = tx_chan_i.ch1;
      m_chan  = expected_rx_pair(mimo_now, m_cap, m_cap_frame, m_pend, m_chan);
      m_valid = !mimo_now || !m_cap_frame;
      if (mimo_now && m_cap_frame)
         m_pend = m_cap;
      // Capture stage, I from fall and Q from rise
      m_cap.i     = rx_pins_i.fall;
      m_cap.q     = rx_pins_i.rise;
      m_cap_frame = rx_pins_i.frame;
      m_phase     = mimo_now ? ~m_phase : 1'b0;
      m_sync      = {m_sync[`E300_SYNC_STAGES-2:0], mimo_i};
      next_strobe = m_sync[`E300_SYNC_STAGES-1] ? m_phase : 1'b1;
   endtask

   always @(negedge siso_clk2) begin
      if (!arst_n_i) begin
         m_sync      = '0;
         m_phase     = 1'b0;
         m_cap       = '0;
         m_cap_frame = 1'b0;
         m_pend      = '0;
         m_chan      = '0;
         m_valid     = 1'b0;
         m_dly       = '0;
         next_strobe = 1'b1;
         tx_exp_q.delete();
         // Pins sit at zero straight out of reset
         tx_exp_q.push_back('0);
      end else begin
         compare_outputs();
         advance_model();
      end
   end

   // ------------------------------------------------------------------------
   // Stimulus
   // ------------------------------------------------------------------------

   task automatic random_sample(output sample_t s);
      logic [31:0] r;
      r   = $random(seed);
      s.i = r[`E300_SAMPLE_W-1:0];
      r   = $random(seed);
      s.q = r[`E300_SAMPLE_W-1:0];
   endtask

   task automatic drive_rx_word(input logic frame);
      sample_t s;
      rx_ddr_t w;
      random_sample(s);
      w.frame = frame;
      w.rise  = s.q;
      w.fall  = s.i;
      rx_pins_i <= w;
   endtask

   // Random zeroing of channel 0 components
   // SISO must fall back to channel 1, MIMO must still send channel 0
   task automatic drive_tx_pair();
      chan_pair_t  c;
      logic [31:0] r;
      random_sample(c.ch0);
      random_sample(c.ch1);
      r = $random(seed);
      if (r[0])
         c.ch0.i = '0;
      if (r[1])
         c.ch0.q = '0;
      tx_chan_i <= c;
   endtask

   // Hard limit on the whole run
   initial begin : watchdog
      int cyc;
      for (cyc = 0; cyc < 1000; cyc++)
         @(posedge siso_clk2);
      abort_run("run exceeded its cycle limit");
   end

   initial begin : main
      int          cyc;
      int          wait_cnt;
      logic [31:0] r;
      arst_n_i  = 1'b0;
      mimo_i    = 1'b0;
      rx_pins_i = '0;
      tx_chan_i = '0;
      rx_siso_pairs = 0;
      rx_mimo_pairs = 0;
      tx_mimo_words = 0;

      // Reset for 2 cycles
      repeat (2) @(posedge siso_clk2);
      arst_n_i <= 1'b1;

      // Reset state, SISO with full-rate strobe
      @(negedge siso_clk2);
      assert (rx_valid_o === 1'b0)
         else report_mismatch("rx_valid_o", 64'(1'b0), 64'(rx_valid_o));
      assert (tx_pins_o === '0)
         else report_mismatch("tx_pins_o", 64'(0), 64'(tx_pins_o));
      assert (radio_strobe_o === 1'b1)
         else report_mismatch("radio_strobe_o", 64'(1'b1), 64'(radio_strobe_o));

      // SISO RX copy and TX loopback
      for (cyc = 0; cyc < 40; cyc++) begin
         @(posedge siso_clk2);
         r = $random(seed);
         drive_rx_word(r[0]);
         drive_tx_pair();
      end

      // Mode switch, strobe must drop within 3 cycles of the edge
      @(posedge siso_clk2);
      mimo_i <= 1'b1;
      wait_cnt = 0;
      do begin
         @(negedge siso_clk2);
         wait_cnt++;
      end while (radio_strobe_o === 1'b1 && wait_cnt < 10);
      if (radio_strobe_o === 1'b1) begin
         abort_run("radio_strobe_o never changed after mimo_i rose");
      end else begin
         assert (wait_cnt <= 3)
            else report_mismatch("strobe_latency", 64'(3), 64'(wait_cnt));
      end

      // MIMO, frames alternate 1/0 and new TX pairs only on strobe cycles
      for (cyc = 0; cyc < 60; cyc++) begin
         @(posedge siso_clk2);
         drive_rx_word(~cyc[0]);
         if (next_strobe)
            drive_tx_pair();
      end

      // Let the pipeline drain
      repeat (4) @(posedge siso_clk2);
      @(negedge siso_clk2);

      if (rx_siso_pairs >= 30 && rx_mimo_pairs >= 25 && tx_mimo_words >= 25) begin
         $display("TB PASSED");
         $finish;
      end else begin
         abort_run("too few RX pairs or MIMO TX words were checked");
      end
   end

endmodule

// File: e300_radio_io.f
+incdir+.
e300_radio_io_pkg.sv
mode_phase_ctrl.sv
rx_deinterleave.sv
tx_interleave.sv
e300_radio_io.sv
tb_e300_radio_io.sv

// File: Makefile
TOP := tb_e300_radio_io

.PHONY: sim clean

# Pass only if the testbench printed its pass line
sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f e300_radio_io.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
